/* logic/exe_settings.svh */
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// datapath and address width
`define XLEN 32

// exception flags coming in from decode
// the stage appends one more bit for misalignment
`define EXC_IN_W 3

// one quotient bit per iteration
`define DIV_STEPS `XLEN

`endif

/* logic/exe_pkg.sv */
package exe_pkg;

    typedef enum logic [3:0]
    {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_nor  = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_e;

    typedef enum logic [2:0]
    {
        md_mul_w   = 3'd0,
        md_mulh_w  = 3'd1,
        md_mulh_wu = 3'd2,
        md_div_w   = 3'd3,
        md_mod_w   = 3'd4,
        md_div_wu  = 3'd5,
        md_mod_wu  = 3'd6
    } md_op_e;

    typedef enum logic
    {
        class_alu = 1'b0,
        class_md  = 1'b1
    } op_class_e;

    // same four bits, read according to op_class_e
    typedef union packed
    {
        alu_op_e alu;
        struct packed
        {
            logic   spare;
            md_op_e op;
        } md;
    } ex_op_u;

    typedef enum logic [3:0]
    {
        mem_none  = 4'd0,
        mem_ld_b  = 4'd1,
        mem_ld_bu = 4'd2,
        mem_ld_h  = 4'd3,
        mem_ld_hu = 4'd4,
        mem_ld_w  = 4'd5,
        mem_st_b  = 4'd6,
        mem_st_h  = 4'd7,
        mem_st_w  = 4'd8
    } mem_op_e;

endpackage

/* logic/alu.sv */
`include "exe_settings.svh"

module alu
(
    input  exe_pkg::alu_op_e  alu_op,
    input  logic [`XLEN-1:0]  alu_src1,
    input  logic [`XLEN-1:0]  alu_src2,
    output logic [`XLEN-1:0]  alu_result
);

    logic              use_sub;
    logic [`XLEN-1:0]  adder_b;
    logic [`XLEN-1:0]  sum;
    logic              carry_out;
    logic              slt_bit;
    logic              sltu_bit;
    logic [4:0]        shamt;

    // sub, slt and sltu all go through the adder as a + ~b + 1
    assign use_sub = (alu_op == exe_pkg::alu_sub) || (alu_op == exe_pkg::alu_slt) ||
                     (alu_op == exe_pkg::alu_sltu);
    assign adder_b = use_sub ? ~alu_src2 : alu_src2;
    assign {carry_out, sum} = {1'b0, alu_src1} + {1'b0, adder_b} + {{`XLEN{1'b0}}, use_sub};

    // signs differ: src1 negative means less
    assign slt_bit = (alu_src1[`XLEN-1] & ~alu_src2[`XLEN-1]) |
                     (~(alu_src1[`XLEN-1] ^ alu_src2[`XLEN-1]) & sum[`XLEN-1]);
    // borrow out of the subtract
    assign sltu_bit = ~carry_out;

    assign shamt = alu_src2[4:0];

    always_comb
    begin
        case (alu_op)
            exe_pkg::alu_add,
            exe_pkg::alu_sub:  alu_result = sum;
            exe_pkg::alu_slt:  alu_result = {{(`XLEN-1){1'b0}}, slt_bit};
            exe_pkg::alu_sltu: alu_result = {{(`XLEN-1){1'b0}}, sltu_bit};
            exe_pkg::alu_and:  alu_result = alu_src1 & alu_src2;
            exe_pkg::alu_or:   alu_result = alu_src1 | alu_src2;
            exe_pkg::alu_nor:  alu_result = ~(alu_src1 | alu_src2);
            exe_pkg::alu_xor:  alu_result = alu_src1 ^ alu_src2;
            exe_pkg::alu_sll:  alu_result = alu_src1 << shamt;
            exe_pkg::alu_srl:  alu_result = alu_src1 >> shamt;
            exe_pkg::alu_sra:  alu_result = $signed(alu_src1) >>> shamt;
            // immediate already shifted by decode
            exe_pkg::alu_lui:  alu_result = alu_src2;
            default:           alu_result = sum;
        endcase
    end

endmodule

/* logic/divider.sv */
`include "exe_settings.svh"

module divider
(
    input  logic              clk,
    input  logic              reset,
    input  logic              div_start,
    input  logic              div_cancel,
    input  logic              div_signed,
    input  logic [`XLEN-1:0]  dividend,
    input  logic [`XLEN-1:0]  divisor,
    output logic              busy,
    output logic              div_done,
    output logic [`XLEN-1:0]  quotient,
    output logic [`XLEN-1:0]  remainder
);

    localparam int cnt_w = $clog2(`DIV_STEPS + 1);

    logic [cnt_w-1:0]  count;
    logic              dividend_neg;
    logic              divisor_neg;
    logic [`XLEN-1:0]  dividend_mag;
    logic [`XLEN-1:0]  divisor_mag;
    logic [`XLEN-1:0]  part_rem;
    logic [`XLEN-1:0]  quo_acc;
    logic [`XLEN-1:0]  div_mag;
    logic              neg_quo;
    logic              neg_rem;
    logic [`XLEN:0]    trial;

    assign dividend_neg = div_signed & dividend[`XLEN-1];
    assign divisor_neg  = div_signed & divisor[`XLEN-1];
    assign dividend_mag = dividend_neg ? -dividend : dividend;
    assign divisor_mag  = divisor_neg ? -divisor : divisor;

    // shift in next dividend bit, try to subtract
    assign trial = {part_rem, quo_acc[`XLEN-1]} - {1'b0, div_mag};

    always_ff @(posedge clk)
    begin
        if (reset || div_cancel)
        begin
            busy     <= 1'b0;
            div_done <= 1'b0;
            count    <= '0;
        end
        else if (div_start)
        begin
            busy     <= 1'b1;
            div_done <= 1'b0;
            count    <= cnt_w'(`DIV_STEPS);
        end
        else if (busy)
        begin
            count <= count - 1'b1;
            if (count == cnt_w'(1))
            begin
                busy     <= 1'b0;
                div_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (div_start)
        begin
            part_rem <= '0;
            quo_acc  <= dividend_mag;
            div_mag  <= divisor_mag;
            // zero divisor keeps the all-ones quotient unsigned
            neg_quo  <= (dividend_neg ^ divisor_neg) & (|divisor);
            neg_rem  <= dividend_neg;
        end
        else if (busy)
        begin
            if (!trial[`XLEN])
            begin
                part_rem <= trial[`XLEN-1:0];
                quo_acc  <= {quo_acc[`XLEN-2:0], 1'b1};
            end
            else
            begin
                part_rem <= {part_rem[`XLEN-2:0], quo_acc[`XLEN-1]};
                quo_acc  <= {quo_acc[`XLEN-2:0], 1'b0};
            end
        end
    end

    // sign fixup, remainder follows the dividend
    assign quotient  = neg_quo ? -quo_acc : quo_acc;
    assign remainder = neg_rem ? -part_rem : part_rem;

    a_no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
        div_start |-> !busy);

endmodule

/* logic/store_align.sv */
`include "exe_settings.svh"

module store_align
(
    input  exe_pkg::mem_op_e  mem_op,
    input  logic [1:0]        addr_low,
    input  logic [`XLEN-1:0]  store_value,
    output logic [3:0]        lane_mask,
    output logic [`XLEN-1:0]  wdata,
    output logic              misaligned
);

    always_comb
    begin
        lane_mask  = 4'b0000;
        wdata      = store_value;
        misaligned = 1'b0;
        case (mem_op)
            exe_pkg::mem_st_b:
            begin
                lane_mask = 4'b0001 << addr_low;
                wdata     = {4{store_value[7:0]}};
            end
            exe_pkg::mem_st_h:
            begin
                lane_mask  = addr_low[1] ? 4'b1100 : 4'b0011;
                wdata      = {2{store_value[15:0]}};
                misaligned = addr_low[0];
            end
            exe_pkg::mem_st_w:
            begin
                lane_mask  = 4'b1111;
                misaligned = |addr_low;
            end
            exe_pkg::mem_ld_h,
            exe_pkg::mem_ld_hu: misaligned = addr_low[0];
            exe_pkg::mem_ld_w:  misaligned = |addr_low;
            default:
            begin
                lane_mask  = 4'b0000;
                misaligned = 1'b0;
            end
        endcase
    end

endmodule

/* logic/exe_stage.sv */
`include "exe_settings.svh"

module exe_stage
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wb_flush,
    input  logic                     mem_ex,
    input  logic                     ms_allowin,
    input  logic                     ds_to_es_valid,
    input  logic [`XLEN-1:0]         ds_pc,
    input  logic [`XLEN-1:0]         ds_rj_value,
    input  logic [`XLEN-1:0]         ds_rkd_value,
    input  logic [`XLEN-1:0]         ds_imm,
    input  logic                     ds_src1_is_pc,
    input  logic                     ds_src2_is_imm,
    input  exe_pkg::op_class_e       ds_op_class,
    input  exe_pkg::ex_op_u          ds_ex_op,
    input  exe_pkg::mem_op_e         ds_mem_op,
    input  logic [4:0]               ds_dest,
    input  logic                     ds_gr_we,
    input  logic [`EXC_IN_W-1:0]     ds_exc,
    output logic                     es_allowin,
    output logic                     es_to_ms_valid,
    output logic                     es_valid,
    output logic                     es_gr_we,
    output logic [`XLEN-1:0]         es_pc,
    output logic [`XLEN-1:0]         es_result,
    output logic [4:0]               es_dest,
    output exe_pkg::mem_op_e         es_mem_op,
    output logic [`EXC_IN_W:0]       es_exc,
    output logic                     data_sram_en,
    output logic [3:0]               data_sram_we,
    output logic [`XLEN-1:0]         data_sram_addr,
    output logic [`XLEN-1:0]         data_sram_wdata
);

    logic [`XLEN-1:0]      rj_r;
    logic [`XLEN-1:0]      rkd_r;
    logic [`XLEN-1:0]      imm_r;
    logic                  src1_is_pc_r;
    logic                  src2_is_imm_r;
    exe_pkg::op_class_e    op_class_r;
    exe_pkg::ex_op_u       ex_op_r;
    logic [`EXC_IN_W-1:0]  exc_r;
    logic [`XLEN-1:0]      alu_src1;
    logic [`XLEN-1:0]      alu_src2;
    logic [`XLEN-1:0]      alu_result;
    exe_pkg::md_op_e       md_op;
    logic                  is_mul;
    logic                  is_div;
    logic                  mul_signed;
    logic [`XLEN:0]        mul_a;
    logic [`XLEN:0]        mul_b;
    logic [2*`XLEN+1:0]    product;
    logic [`XLEN-1:0]      mul_result;
    logic                  div_start;
    logic                  div_sent;
    logic                  div_busy;
    logic                  div_done;
    logic [`XLEN-1:0]      quotient;
    logic [`XLEN-1:0]      remainder;
    logic                  es_ready_go;
    logic [3:0]            lane_mask;
    logic                  misaligned;

    always_ff @(posedge clk)
    begin
        if (reset || wb_flush)
            es_valid <= 1'b0;
        else if (es_allowin)
            es_valid <= ds_to_es_valid;
    end

    always_ff @(posedge clk)
    begin
        if (ds_to_es_valid && es_allowin)
        begin
            es_pc         <= ds_pc;
            rj_r          <= ds_rj_value;
            rkd_r         <= ds_rkd_value;
            imm_r         <= ds_imm;
            src1_is_pc_r  <= ds_src1_is_pc;
            src2_is_imm_r <= ds_src2_is_imm;
            op_class_r    <= ds_op_class;
            ex_op_r       <= ds_ex_op;
            es_mem_op     <= ds_mem_op;
            es_dest       <= ds_dest;
            es_gr_we      <= ds_gr_we;
            exc_r         <= ds_exc;
        end
    end

    assign alu_src1 = src1_is_pc_r ? es_pc : rj_r;
    assign alu_src2 = src2_is_imm_r ? imm_r : rkd_r;

    alu alu_inst
    (
        .alu_op     (ex_op_r.alu),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    assign md_op  = ex_op_r.md.op;
    assign is_mul = (op_class_r == exe_pkg::class_md) &&
                    (md_op inside {exe_pkg::md_mul_w, exe_pkg::md_mulh_w, exe_pkg::md_mulh_wu});
    assign is_div = (op_class_r == exe_pkg::class_md) &&
                    (md_op inside {exe_pkg::md_div_w, exe_pkg::md_mod_w,
                                   exe_pkg::md_div_wu, exe_pkg::md_mod_wu});

    // 33x33 signed product covers both signed and unsigned high words
    assign mul_signed = (md_op == exe_pkg::md_mulh_w);
    assign mul_a      = {mul_signed & alu_src1[`XLEN-1], alu_src1};
    assign mul_b      = {mul_signed & alu_src2[`XLEN-1], alu_src2};
    assign product    = $signed(mul_a) * $signed(mul_b);
    assign mul_result = (md_op == exe_pkg::md_mul_w) ? product[`XLEN-1:0]
                                                      : product[2*`XLEN-1:`XLEN];

    // one start per divide; cleared when the slot turns over or on flush
    assign div_start = es_valid && is_div && !div_busy && !div_sent && !wb_flush;

    always_ff @(posedge clk)
    begin
        if (reset || wb_flush || es_allowin)
            div_sent <= 1'b0;
        else if (div_start)
            div_sent <= 1'b1;
    end

    divider divider_inst
    (
        .clk        (clk),
        .reset      (reset),
        .div_start  (div_start),
        .div_cancel (wb_flush),
        .div_signed (md_op == exe_pkg::md_div_w || md_op == exe_pkg::md_mod_w),
        .dividend   (alu_src1),
        .divisor    (alu_src2),
        .busy       (div_busy),
        .div_done   (div_done),
        .quotient   (quotient),
        .remainder  (remainder)
    );

    assign es_ready_go    = !is_div || (div_sent && div_done);
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;

    always_comb
    begin
        if (is_mul)
            es_result = mul_result;
        else if (is_div)
            es_result = (md_op == exe_pkg::md_div_w || md_op == exe_pkg::md_div_wu) ?
                        quotient : remainder;
        else
            es_result = alu_result;
    end

    store_align store_align_inst
    (
        .mem_op      (es_mem_op),
        .addr_low    (alu_result[1:0]),
        .store_value (rkd_r),
        .lane_mask   (lane_mask),
        .wdata       (data_sram_wdata),
        .misaligned  (misaligned)
    );

    assign es_exc          = {exc_r, misaligned};
    assign data_sram_en    = es_valid;
    assign data_sram_addr  = alu_result;
    assign data_sram_we    = (es_valid && !misaligned && !mem_ex) ? lane_mask : 4'b0000;

    // a result held by the memory stage stays put
    a_out_valid: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allowin && !wb_flush |=>
            es_valid && es_to_ms_valid && $stable(es_result));

    a_we_store_only: assert property (@(posedge clk) disable iff (reset)
        (data_sram_we != 4'b0000) |->
            (es_mem_op inside {exe_pkg::mem_st_b, exe_pkg::mem_st_h, exe_pkg::mem_st_w}));

    // a fresh start clears the old divider result and fires only once
    a_start_not_pending: assert property (@(posedge clk) disable iff (reset)
        div_start |=> !es_to_ms_valid && !div_start);

endmodule

/* testbench/exe_tb_tasks.svh */
`ifndef EXE_TB_TASKS_SVH
`define EXE_TB_TASKS_SVH

task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first failure");
endtask

task automatic compare_word(input string what, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
    if (got !== exp)
        abort_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic compare_mask(input string what, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp)
        abort_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
endtask

task automatic compare_exc(input string what, input logic [`EXC_IN_W:0] got,
                           input logic [`EXC_IN_W:0] exp);
    if (got !== exp)
        abort_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
endtask

task automatic compare_mem_op(input string what, input exe_pkg::mem_op_e got,
                              input exe_pkg::mem_op_e exp);
    if (got !== exp)
        abort_run($sformatf("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
endtask

task automatic compare_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
        abort_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
endtask

task automatic present_op(input exe_pkg::op_class_e cls, input exe_pkg::ex_op_u op,
                          input exe_pkg::mem_op_e mop, input logic [`XLEN-1:0] pc,
                          input logic [`XLEN-1:0] rj, input logic [`XLEN-1:0] rkd,
                          input logic [`XLEN-1:0] imm, input logic s1pc, input logic s2imm,
                          input logic [`EXC_IN_W-1:0] exc);
    @(negedge clk);
    ds_op_class    = cls;
    ds_ex_op       = op;
    ds_mem_op      = mop;
    ds_pc          = pc;
    ds_rj_value    = rj;
    ds_rkd_value   = rkd;
    ds_imm         = imm;
    ds_src1_is_pc  = s1pc;
    ds_src2_is_imm = s2imm;
    ds_exc         = exc;
    ds_dest        = rkd[4:0];
    ds_gr_we       = rkd[5];
    ds_to_es_valid = 1'b1;
endtask

// returns on the falling edge right after the accepting edge
task automatic issue_op();
    int waited;
    waited = 0;
    #1;
    while (es_allowin !== 1'b1)
    begin
        if (waited == 100)
            abort_run("es_allowin never rose while an instruction waited to issue");
        waited++;
        @(negedge clk);
        #1;
    end
    @(posedge clk);
    @(negedge clk);
    ds_to_es_valid = 1'b0;
endtask

task automatic wait_result();
    int waited;
    waited = 0;
    while (es_to_ms_valid !== 1'b1)
    begin
        if (waited == 100)
            abort_run("es_to_ms_valid never rose after an instruction was accepted");
        waited++;
        @(negedge clk);
    end
endtask

task automatic run_md_op(input exe_pkg::md_op_e op, input logic [`XLEN-1:0] a,
                         input logic [`XLEN-1:0] b);
    present_op(exe_pkg::class_md, md_word(op), exe_pkg::mem_none, 32'h1c00_0000, a, b, '0,
               1'b0, 1'b0, '0);
    issue_op();
    wait_result();
    compare_word($sformatf("%s of %h and %h", op.name(), a, b), es_result, md_model(op, a, b));
endtask

task automatic alu_sweep();
    logic [`XLEN-1:0]     pc;
    logic [`XLEN-1:0]     rj;
    logic [`XLEN-1:0]     rkd;
    logic [`XLEN-1:0]     imm;
    logic [1:0]           sel;
    logic [`EXC_IN_W-1:0] exc;
    exe_pkg::alu_op_e     op;
    for (int i = 0; i < 12; i++)
    begin
        op = exe_pkg::alu_op_e'(i);
        repeat (4)
        begin
            pc  = random_bits(`XLEN);
            rj  = random_bits(`XLEN);
            rkd = random_bits(`XLEN);
            imm = random_bits(`XLEN);
            sel = 2'(random_bits(2));
            exc = `EXC_IN_W'(random_bits(`EXC_IN_W));
            present_op(exe_pkg::class_alu, alu_word(op), exe_pkg::mem_none, pc, rj, rkd, imm,
                       sel[1], sel[0], exc);
            issue_op();
            compare_bit("es_to_ms_valid one cycle after accept", es_to_ms_valid, 1'b1);
            compare_word($sformatf("%s result", op.name()), es_result,
                         alu_model(op, sel[1] ? pc : rj, sel[0] ? imm : rkd));
            compare_word("es_pc", es_pc, pc);
            compare_word("es_dest", 32'(es_dest), 32'(rkd[4:0]));
            compare_bit("es_gr_we", es_gr_we, rkd[5]);
            compare_exc("es_exc", es_exc, {exc, 1'b0});
            compare_mem_op("es_mem_op", es_mem_op, exe_pkg::mem_none);
        end
    end
endtask

// corner pairs, then random pairs, small divisors and zero divisors
task automatic operand_grid(input exe_pkg::md_op_e op);
    logic [`XLEN-1:0] corner [5];
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    corner = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    foreach (corner[i])
        foreach (corner[j])
            run_md_op(op, corner[i], corner[j]);
    repeat (6)
    begin
        a = random_bits(`XLEN);
        b = random_bits(`XLEN);
        run_md_op(op, a, b);
        b = random_bits(9);
        run_md_op(op, a, b);
        run_md_op(op, a, '0);
    end
endtask

task automatic multiply_cases();
    operand_grid(exe_pkg::md_mul_w);
    operand_grid(exe_pkg::md_mulh_w);
    operand_grid(exe_pkg::md_mulh_wu);
endtask

task automatic divide_cases();
    operand_grid(exe_pkg::md_div_w);
    operand_grid(exe_pkg::md_mod_w);
    operand_grid(exe_pkg::md_div_wu);
    operand_grid(exe_pkg::md_mod_wu);
endtask

// lane mask, replicated data and misalignment for one access
task automatic expect_access(input exe_pkg::mem_op_e mop, input logic [1:0] off,
                             input logic [`XLEN-1:0] value, output logic [3:0] mask,
                             output logic [`XLEN-1:0] data, output logic mis);
    int size;
    case (mop)
        exe_pkg::mem_ld_h, exe_pkg::mem_ld_hu, exe_pkg::mem_st_h: size = 2;
        exe_pkg::mem_ld_w, exe_pkg::mem_st_w:                      size = 4;
        default:                                                   size = 1;
    endcase
    mis = (off % size) != 0;
    // each lane holds the byte of the value at the same offset within the access
    for (int lane = 0; lane < 4; lane++)
    begin
        data[8*lane +: 8] = value[8*(lane % size) +: 8];
        mask[lane]        = (mop inside {exe_pkg::mem_st_b, exe_pkg::mem_st_h,
                                         exe_pkg::mem_st_w}) && (lane / size == off / size);
    end
endtask

task automatic memory_access_cases();
    exe_pkg::mem_op_e mop;
    logic [`XLEN-1:0] base;
    logic [`XLEN-1:0] value;
    logic [`XLEN-1:0] data;
    logic [3:0]       mask;
    logic             mis;
    string            what;
    for (int m = 1; m <= 8; m++)
        for (int off = 0; off < 4; off++)
            for (int ex = 0; ex < 2; ex++)
            begin
                mop   = exe_pkg::mem_op_e'(m);
                base  = random_bits(`XLEN) & ~32'h3;
                value = random_bits(`XLEN);
                what  = $sformatf("%s at offset %0d, mem_ex %0d", mop.name(), off, ex);
                expect_access(mop, off[1:0], value, mask, data, mis);
                mem_ex = ex[0];
                present_op(exe_pkg::class_alu, alu_word(exe_pkg::alu_add), mop, 32'h1c00_0100,
                           base, value, `XLEN'(off), 1'b0, 1'b1, '0);
                issue_op();
                compare_mask({"data_sram_we for ", what}, data_sram_we,
                             (mis || ex[0]) ? 4'b0000 : mask);
                compare_word({"data_sram_addr for ", what}, data_sram_addr, base + `XLEN'(off));
                compare_exc({"es_exc for ", what}, es_exc, {{`EXC_IN_W{1'b0}}, mis});
                compare_mem_op({"es_mem_op for ", what}, es_mem_op, mop);
                compare_bit({"data_sram_en for ", what}, data_sram_en, 1'b1);
                if (mop inside {exe_pkg::mem_st_b, exe_pkg::mem_st_h, exe_pkg::mem_st_w})
                    compare_word({"data_sram_wdata for ", what}, data_sram_wdata, data);
            end
    mem_ex = 1'b0;
endtask

task automatic backpressure_hold();
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] c;
    logic [`XLEN-1:0] d;
    a = random_bits(`XLEN);
    b = random_bits(`XLEN);
    c = random_bits(`XLEN);
    d = random_bits(`XLEN);
    @(negedge clk);
    ms_allowin = 1'b0;
    present_op(exe_pkg::class_alu, alu_word(exe_pkg::alu_add), exe_pkg::mem_none,
               32'h1c00_0200, a, b, '0, 1'b0, 1'b0, 3'b010);
    issue_op();
    // a second instruction waits at the input the whole time
    present_op(exe_pkg::class_alu, alu_word(exe_pkg::alu_sub), exe_pkg::mem_ld_b,
               32'h1c00_0204, c, d, '0, 1'b0, 1'b0, 3'b101);
    repeat (4)
    begin
        compare_bit("es_allowin under back-pressure", es_allowin, 1'b0);
        compare_bit("es_to_ms_valid under back-pressure", es_to_ms_valid, 1'b1);
        compare_word("held es_result", es_result, a + b);
        compare_word("held es_pc", es_pc, 32'h1c00_0200);
        compare_word("held es_dest", 32'(es_dest), 32'(b[4:0]));
        compare_bit("held es_gr_we", es_gr_we, b[5]);
        compare_exc("held es_exc", es_exc, 4'b0100);
        compare_mem_op("held es_mem_op", es_mem_op, exe_pkg::mem_none);
        @(negedge clk);
    end
    ms_allowin = 1'b1;
    issue_op();
    compare_word("result after release", es_result, c - d);
    compare_word("es_pc after release", es_pc, 32'h1c00_0204);
    compare_exc("es_exc after release", es_exc, 4'b1010);
    compare_mem_op("es_mem_op after release", es_mem_op, exe_pkg::mem_ld_b);
    // divide finishing while the memory stage is stalled
    @(negedge clk);
    ms_allowin = 1'b0;
    run_md_op(exe_pkg::md_div_w, a, b >> 20);
    repeat (4)
    begin
        compare_bit("es_allowin with divide held", es_allowin, 1'b0);
        compare_bit("es_to_ms_valid with divide held", es_to_ms_valid, 1'b1);
        compare_word("held divide result", es_result, md_model(exe_pkg::md_div_w, a, b >> 20));
        @(negedge clk);
    end
    ms_allowin = 1'b1;
    @(negedge clk);
    compare_bit("es_valid after held divide left", es_valid, 1'b0);
endtask

task automatic flush_recovery();
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    a = random_bits(`XLEN);
    b = random_bits(`XLEN);
    @(negedge clk);
    ms_allowin = 1'b0;
    present_op(exe_pkg::class_alu, alu_word(exe_pkg::alu_xor), exe_pkg::mem_none,
               32'h1c00_0300, a, b, '0, 1'b0, 1'b0, '0);
    issue_op();
    compare_bit("es_to_ms_valid before flush", es_to_ms_valid, 1'b1);
    wb_flush = 1'b1;
    @(negedge clk);
    wb_flush   = 1'b0;
    ms_allowin = 1'b1;
    compare_bit("es_valid after ALU flush", es_valid, 1'b0);
    compare_bit("es_to_ms_valid after ALU flush", es_to_ms_valid, 1'b0);
    present_op(exe_pkg::class_md, md_word(exe_pkg::md_mod_wu), exe_pkg::mem_none,
               32'h1c00_0304, a, b >> 4, '0, 1'b0, 1'b0, '0);
    issue_op();
    repeat (10) @(negedge clk);
    compare_bit("es_to_ms_valid mid divide", es_to_ms_valid, 1'b0);
    wb_flush = 1'b1;
    @(negedge clk);
    wb_flush = 1'b0;
    compare_bit("es_valid after divide flush", es_valid, 1'b0);
    compare_bit("divider busy after flush", exe_stage_inst.div_busy, 1'b0);
    repeat (40)
    begin
        compare_bit("es_to_ms_valid after divide flush", es_to_ms_valid, 1'b0);
        @(negedge clk);
    end
    run_md_op(exe_pkg::md_div_w, b, a >> 24);
    run_md_op(exe_pkg::md_mod_w, a, b >> 12);
    present_op(exe_pkg::class_alu, alu_word(exe_pkg::alu_or), exe_pkg::mem_none,
               32'h1c00_0308, a, b, '0, 1'b0, 1'b0, '0);
    issue_op();
    compare_word("ALU result after flush", es_result, a | b);
endtask

`endif

/* testbench/exe_stage_tb.sv */
`include "exe_settings.svh"

module exe_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                  clk;
    logic                  reset;
    logic                  wb_flush;
    logic                  mem_ex;
    logic                  ms_allowin;
    logic                  ds_to_es_valid;
    logic [`XLEN-1:0]      ds_pc;
    logic [`XLEN-1:0]      ds_rj_value;
    logic [`XLEN-1:0]      ds_rkd_value;
    logic [`XLEN-1:0]      ds_imm;
    logic                  ds_src1_is_pc;
    logic                  ds_src2_is_imm;
    exe_pkg::op_class_e    ds_op_class;
    exe_pkg::ex_op_u       ds_ex_op;
    exe_pkg::mem_op_e      ds_mem_op;
    logic [4:0]            ds_dest;
    logic                  ds_gr_we;
    logic [`EXC_IN_W-1:0]  ds_exc;
    logic                  es_allowin;
    logic                  es_to_ms_valid;
    logic                  es_valid;
    logic                  es_gr_we;
    logic [`XLEN-1:0]      es_pc;
    logic [`XLEN-1:0]      es_result;
    logic [4:0]            es_dest;
    exe_pkg::mem_op_e      es_mem_op;
    logic [`EXC_IN_W:0]    es_exc;
    logic                  data_sram_en;
    logic [3:0]            data_sram_we;
    logic [`XLEN-1:0]      data_sram_addr;
    logic [`XLEN-1:0]      data_sram_wdata;
    logic [31:0]           lfsr_state;

    exe_stage exe_stage_inst (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return value;
    endfunction

    function automatic exe_pkg::ex_op_u alu_word(input exe_pkg::alu_op_e op);
        exe_pkg::ex_op_u word;
        word.alu = op;
        return word;
    endfunction

    function automatic exe_pkg::ex_op_u md_word(input exe_pkg::md_op_e op);
        exe_pkg::ex_op_u word;
        word.md.spare = 1'b0;
        word.md.op    = op;
        return word;
    endfunction

    function automatic logic [`XLEN-1:0] alu_model(input exe_pkg::alu_op_e op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        case (op)
            exe_pkg::alu_add:  return a + b;
            exe_pkg::alu_sub:  return a - b;
            exe_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            exe_pkg::alu_sltu: return (a < b) ? 1 : 0;
            exe_pkg::alu_and:  return a & b;
            exe_pkg::alu_or:   return a | b;
            exe_pkg::alu_nor:  return ~(a | b);
            exe_pkg::alu_xor:  return a ^ b;
            exe_pkg::alu_sll:  return a << b[4:0];
            exe_pkg::alu_srl:  return a >> b[4:0];
            exe_pkg::alu_sra:  return $signed(a) >>> b[4:0];
            default:           return b;
        endcase
    endfunction

    // 64-bit products; signed divide in 64 bits also covers the overflow case
    function automatic logic [`XLEN-1:0] md_model(input exe_pkg::md_op_e op,
                                                  input logic [`XLEN-1:0] a,
                                                  input logic [`XLEN-1:0] b);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        sa = $signed(a);
        sb = $signed(b);
        ua = a;
        ub = b;
        case (op)
            exe_pkg::md_mul_w:   return `XLEN'(sa * sb);
            exe_pkg::md_mulh_w:  return `XLEN'((sa * sb) >>> 32);
            exe_pkg::md_mulh_wu: return `XLEN'((ua * ub) >> 32);
            exe_pkg::md_div_w:   return (b == 0) ? '1 : `XLEN'(sa / sb);
            exe_pkg::md_mod_w:   return (b == 0) ? a : `XLEN'(sa % sb);
            exe_pkg::md_div_wu:  return (b == 0) ? '1 : a / b;
            exe_pkg::md_mod_wu:  return (b == 0) ? a : a % b;
            default:             return '0;
        endcase
    endfunction

    `include "exe_tb_tasks.svh"

    initial
    begin
        lfsr_state     = 32'h8b7e_0d87;
        reset          = 1'b1;
        wb_flush       = 1'b0;
        mem_ex         = 1'b0;
        ms_allowin     = 1'b1;
        ds_to_es_valid = 1'b0;
        ds_pc          = '0;
        ds_rj_value    = '0;
        ds_rkd_value   = '0;
        ds_imm         = '0;
        ds_src1_is_pc  = 1'b0;
        ds_src2_is_imm = 1'b0;
        ds_op_class    = exe_pkg::class_alu;
        ds_ex_op       = alu_word(exe_pkg::alu_add);
        ds_mem_op      = exe_pkg::mem_none;
        ds_dest        = '0;
        ds_gr_we       = 1'b0;
        ds_exc         = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        compare_bit("es_valid after reset", es_valid, 1'b0);
        compare_bit("es_to_ms_valid after reset", es_to_ms_valid, 1'b0);
        compare_bit("data_sram_en after reset", data_sram_en, 1'b0);
        compare_mask("data_sram_we after reset", data_sram_we, 4'b0000);
        compare_bit("div_done after reset", exe_stage_inst.div_done, 1'b0);
        compare_bit("divider busy after reset", exe_stage_inst.div_busy, 1'b0);
        alu_sweep();
        multiply_cases();
        divide_cases();
        memory_access_cases();
        backpressure_hold();
        flush_recovery();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* exe_stage.f */
+incdir+logic
+incdir+testbench
logic/exe_pkg.sv
logic/alu.sv
logic/divider.sv
logic/store_align.sv
logic/exe_stage.sv
testbench/exe_stage_tb.sv
